/* sccb_patterns.txt */
// first value is the frame count, then per frame:
// dev_addr reg_addr data ack_mask bytes success extra
// ack_mask bit 0 acks the device address, bit 1 the register, bit 2 the data
// extra bit 0 repeats go while busy, bit 1 writes an unused register first
0a
42 0a 5c 7 3 1 0
42 0b 33 0 1 0 0
21 12 a5 1 2 0 0
60 3c 0f 3 3 0 0
60 3d f0 7 3 1 0
78 01 c3 7 3 1 1
78 02 96 7 3 1 2
ff 00 81 7 3 1 0
30 55 aa 5 2 0 0
30 56 aa 6 1 0 3

/* flist.f */
sccb_pkg.sv
sccb_reg_bank.sv
sccb_frame_sequencer.sv
sccb_line_driver.sv
sccb_master.sv
tb_sccb_target.sv
tb_sccb_master.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the SCCB host and its testbench with Verilator, run, and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_sccb_master -f flist.f -o tb_sccb_sim > build.log 2>&1 \
	&& ./obj_dir/tb_sccb_sim > sim.log 2>&1 \
	|| { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

cat sim.log
grep -qx "Regression passed" sim.log && exit 0 || exit 1

/* tb_sccb_master.sv */
`timescale 1ns/1ps

module tb_sccb_master;

	localparam int max_frames = 16;
	localparam int fields = 7;

	logic clk_div_2 = 1'b0;
	logic reset_n;
	sccb_pkg::host_write_t host;
	logic sda_in;
	sccb_pkg::sccb_bus_t bus;
	logic ready;
	logic success_out;

	logic [2:0] ack_mask;
	logic [2:0][7:0] captured;
	int byte_count;
	int start_count;
	int stop_count;

	// entry 0 is the frame count, then seven fields per frame
	logic [7:0] patterns [0:max_frames*fields];
	int error_count;
	int check_count;

	always #5 clk_div_2 = ~clk_div_2;

	sccb_master dut
	(
		.clk_div_2 (clk_div_2),
		.reset_n (reset_n),
		.host (host),
		.sda_in (sda_in),
		.bus (bus),
		.ready (ready),
		.success_out (success_out)
	);

	tb_sccb_target target
	(
		.clk_div_2 (clk_div_2),
		.bus (bus),
		.ack_mask (ack_mask),
		.sda_in (sda_in),
		.captured (captured),
		.byte_count (byte_count),
		.start_count (start_count),
		.stop_count (stop_count)
	);

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		assert (actual === expected)
		else
		begin
			error_count++;
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic check_condition(input logic ok, input string what);
		check_count++;
		assert (ok)
		else
		begin
			error_count++;
			$display("%s", what);
		end
	endtask

	////////////////////////////////////////
	// host side
	////////////////////////////////////////

	// called on a falling edge, returns one cycle later
	task automatic host_write(input sccb_pkg::reg_addr_t address, input logic [7:0] value);
		host.write = 1'b1;
		host.address = address;
		host.writedata = value;
		@(negedge clk_div_2);
		host = '0;
	endtask

	task automatic wait_ready(input logic level, input int limit, input string what);
		int cycles;
		cycles = 0;
		while (ready !== level && cycles < limit)
		begin
			@(negedge clk_div_2);
			cycles++;
		end
		check_condition(ready === level, what);
	endtask

	task automatic run_frame(input int index);
		int base;
		int starts_before;
		int stops_before;
		int i;
		logic [2:0][7:0] expected;
		logic [7:0] exp_count;
		logic [7:0] exp_success;
		logic [7:0] extra;
		base = 1 + index * fields;
		expected[0] = patterns[base];
		expected[1] = patterns[base+1];
		expected[2] = patterns[base+2];
		ack_mask = patterns[base+3][2:0];
		exp_count = patterns[base+4];
		exp_success = patterns[base+5];
		extra = patterns[base+6];
		starts_before = start_count;
		stops_before = stop_count;

		host_write(sccb_pkg::reg_slave_address, expected[0]);
		host_write(sccb_pkg::reg_reg_address, expected[1]);
		host_write(sccb_pkg::reg_data, expected[2]);
		if (extra[1])
			host_write(sccb_pkg::reg_addr_t'(5), ~expected[2]);
		host_write(sccb_pkg::reg_control, 8'h01 << sccb_pkg::go_bit);

		wait_ready(1'b0, 8, $sformatf("frame %0d: ready did not fall after go", index));
		// flag is cleared as the frame starts
		check_value("success_out", 32'h0, success_out);
		if (extra[0])
			host_write(sccb_pkg::reg_control, 8'h01 << sccb_pkg::go_bit);
		wait_ready(1'b1, 120, $sformatf("frame %0d: ready did not return", index));

		// gap between frames, long enough for a stray frame to start
		repeat (6) @(negedge clk_div_2);

		check_condition(start_count == starts_before + 1,
			$sformatf("frame %0d: target did not see exactly one start", index));
		check_condition(stop_count == stops_before + 1,
			$sformatf("frame %0d: target did not see exactly one stop", index));
		check_value("ready", 32'h1, ready);
		check_value("success_out", exp_success, success_out);
		check_value("byte_count", exp_count, byte_count);
		for (i = 0; i < 3; i++)
		begin
			if (i < exp_count)
				check_value($sformatf("captured[%0d]", i), expected[i], captured[i]);
		end
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial
	begin
		int frame_count;
		int n;
		error_count = 0;
		check_count = 0;
		reset_n = 1'b0;
		host = '0;
		ack_mask = 3'b000;
		$readmemh("sccb_patterns.txt", patterns);
		frame_count = patterns[0];

		repeat (10) @(negedge clk_div_2);
		reset_n = 1'b1;
		@(negedge clk_div_2);

		// idle bus after reset
		check_value("ready", 32'h1, ready);
		check_value("success_out", 32'h0, success_out);
		check_value("bus.scl", 32'h1, bus.scl);
		check_value("bus.sda", 32'h1, bus.sda);
		check_value("bus.sda_oe", 32'h1, bus.sda_oe);

		check_condition(frame_count > 0 && frame_count <= max_frames,
			"pattern file holds no valid frame count");
		for (n = 0; n < frame_count && n < max_frames; n++)
			run_frame(n);

		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* tb_sccb_target.sv */
`timescale 1ns/1ps

module tb_sccb_target
(
	input logic clk_div_2,
	input sccb_pkg::sccb_bus_t bus,
	input logic [2:0] ack_mask,
	output logic sda_in,
	output logic [2:0][7:0] captured,
	output int byte_count,
	output int start_count,
	output int stop_count
);

	logic in_frame;
	logic prev_scl;
	logic prev_sda;
	logic line_sda;
	logic [7:0] shift;
	int bit_count;

	// released line reads back the level the target drives
	assign line_sda = bus.sda_oe ? bus.sda : sda_in;

	// hold sda low through the ack slot of an acked byte
	always_comb
	begin
		sda_in = 1'b1;
		if (in_frame && !bus.sda_oe)
		begin
			case (byte_count)
				1: sda_in = ~ack_mask[0];
				2: sda_in = ~ack_mask[1];
				3: sda_in = ~ack_mask[2];
				default: sda_in = 1'b1;
			endcase
		end
	end

	initial
	begin
		in_frame <= 1'b0;
		prev_scl <= 1'b1;
		prev_sda <= 1'b1;
		shift <= '0;
		bit_count <= 0;
		captured <= '0;
		byte_count <= 0;
		start_count <= 0;
		stop_count <= 0;
	end

	// bus is stable at the falling clock edge
	always @(negedge clk_div_2)
	begin
		prev_scl <= bus.scl;
		prev_sda <= line_sda;
		if (prev_scl && bus.scl && prev_sda && !line_sda && !in_frame)
		begin
			in_frame <= 1'b1;
			bit_count <= 0;
			byte_count <= 0;
			start_count <= start_count + 1;
		end
		else if (prev_scl && bus.scl && !prev_sda && line_sda && in_frame)
		begin
			in_frame <= 1'b0;
			stop_count <= stop_count + 1;
		end
		else if (!prev_scl && bus.scl && in_frame)
		begin
			if (bit_count == 8)
			begin
				// ack slot clock
				bit_count <= 0;
			end
			else
			begin
				shift <= {shift[6:0], line_sda};
				bit_count <= bit_count + 1;
				if (bit_count == 7 && byte_count < 3)
				begin
					captured[byte_count] <= {shift[6:0], line_sda};
					byte_count <= byte_count + 1;
				end
			end
		end
	end

endmodule

/* sccb_master.sv */
`timescale 1ns/1ps

module sccb_master
(
	input logic clk_div_2,
	input logic reset_n,
	input sccb_pkg::host_write_t host,
	input logic sda_in,
	output sccb_pkg::sccb_bus_t bus,
	output logic ready,
	output logic success_out
);

	sccb_pkg::sccb_frame_t frame;
	sccb_pkg::line_cmd_t cmd;
	logic go;
	logic busy;

	sccb_reg_bank u_reg_bank
	(
		.clk_div_2 (clk_div_2),
		.reset_n (reset_n),
		.host (host),
		.busy (busy),
		.frame (frame),
		.go (go)
	);

	sccb_frame_sequencer u_frame_sequencer
	(
		.clk_div_2 (clk_div_2),
		.reset_n (reset_n),
		.frame (frame),
		.go (go),
		.sda_in (sda_in),
		.busy (busy),
		.cmd (cmd)
	);

	sccb_line_driver u_line_driver
	(
		.clk_div_2 (clk_div_2),
		.reset_n (reset_n),
		.cmd (cmd),
		.bus (bus),
		.ready (ready),
		.success_out (success_out)
	);

endmodule

/* sccb_line_driver.sv */
`timescale 1ns/1ps

module sccb_line_driver
(
	input logic clk_div_2,
	input logic reset_n,
	input sccb_pkg::line_cmd_t cmd,
	output sccb_pkg::sccb_bus_t bus,
	output logic ready,
	output logic success_out
);

	logic frame_start;

	// idle always asks for sda high, so the first low request is the start
	assign frame_start = ready && !cmd.sda;

	////////////////////////////////////////
	// bus lines
	////////////////////////////////////////

	always_ff @(posedge clk_div_2)
	begin
		if (!reset_n)
		begin
			bus.scl <= 1'b1;
			bus.sda <= 1'b1;
			bus.sda_oe <= 1'b1;
		end
		else
		begin
			bus.sda <= cmd.sda;
			bus.sda_oe <= cmd.sda_oe;
			case (cmd.scl_mode)
				sccb_pkg::scl_toggle:
					bus.scl <= ~bus.scl;
				sccb_pkg::scl_hold_low:
					bus.scl <= 1'b0;
				default:
					bus.scl <= 1'b1;
			endcase
		end
	end

	////////////////////////////////////////
	// host status
	////////////////////////////////////////

	always_ff @(posedge clk_div_2)
	begin
		if (!reset_n)
		begin
			ready <= 1'b1;
		end
		else if (frame_start)
		begin
			ready <= 1'b0;
		end
		else if (cmd.frame_done)
		begin
			ready <= 1'b1;
		end
	end

	// sticky until the next frame starts
	always_ff @(posedge clk_div_2)
	begin
		if (!reset_n)
		begin
			success_out <= 1'b0;
		end
		else if (frame_start)
		begin
			success_out <= 1'b0;
		end
		else if (cmd.frame_done && cmd.data_ack_ok)
		begin
			success_out <= 1'b1;
		end
	end

endmodule

/* sccb_frame_sequencer.sv */
`timescale 1ns/1ps

module sccb_frame_sequencer
(
	input logic clk_div_2,
	input logic reset_n,
	input sccb_pkg::sccb_frame_t frame,
	input logic go,
	input logic sda_in,
	output logic busy,
	output sccb_pkg::line_cmd_t cmd
);

	// phase 0 is the scl low half of a bit, phase 1 the high half
	logic phase;

	sccb_pkg::frame_state_t state;
	sccb_pkg::frame_state_t state_n;
	sccb_pkg::byte_sel_t byte_sel;
	sccb_pkg::byte_sel_t byte_sel_n;
	sccb_pkg::bit_index_t bit_cnt;
	sccb_pkg::bit_index_t bit_cnt_n;
	logic data_acked;
	logic data_acked_n;
	logic [sccb_pkg::byte_bits-1:0] shift_byte;

	assign busy = (state != sccb_pkg::idle);

	////////////////////////////////////////
	// next state
	////////////////////////////////////////

	always_comb
	begin
		state_n = state;
		byte_sel_n = byte_sel;
		bit_cnt_n = bit_cnt;
		data_acked_n = data_acked;
		case (state)
			sccb_pkg::idle:
			begin
				// start on phase 1 so the first bit opens with a low half
				if (go && phase)
					state_n = sccb_pkg::start_low_sda;
			end
			sccb_pkg::start_low_sda:
			begin
				state_n = sccb_pkg::start_low_scl;
				data_acked_n = 1'b0;
			end
			sccb_pkg::start_low_scl:
			begin
				state_n = sccb_pkg::byte_shift;
				byte_sel_n = sccb_pkg::device_address;
				bit_cnt_n = sccb_pkg::bit_index_t'(sccb_pkg::byte_bits - 1);
			end
			sccb_pkg::byte_shift:
			begin
				if (phase)
				begin
					if (bit_cnt == '0)
						state_n = sccb_pkg::ack_slot;
					else
						bit_cnt_n = bit_cnt - 1'b1;
				end
			end
			sccb_pkg::ack_slot:
			begin
				// scl is high on the bus now, so sda_in holds the ack
				if (phase)
				begin
					bit_cnt_n = sccb_pkg::bit_index_t'(sccb_pkg::byte_bits - 1);
					if (byte_sel == sccb_pkg::data)
					begin
						data_acked_n = ~sda_in;
						state_n = sccb_pkg::stop_scl_high;
					end
					else if (sda_in)
					begin
						// no ack on address or register, abort
						state_n = sccb_pkg::stop_scl_high;
					end
					else
					begin
						state_n = sccb_pkg::byte_shift;
						byte_sel_n = (byte_sel == sccb_pkg::device_address) ?
							sccb_pkg::register_address : sccb_pkg::data;
					end
				end
			end
			sccb_pkg::stop_scl_high:
			begin
				state_n = sccb_pkg::stop_sda_high;
			end
			default:
			begin
				state_n = sccb_pkg::idle;
			end
		endcase
	end

	always_ff @(posedge clk_div_2)
	begin
		if (!reset_n)
		begin
			phase <= 1'b0;
			state <= sccb_pkg::idle;
			byte_sel <= sccb_pkg::device_address;
			bit_cnt <= '0;
			data_acked <= 1'b0;
		end
		else
		begin
			phase <= ~phase;
			state <= state_n;
			byte_sel <= byte_sel_n;
			bit_cnt <= bit_cnt_n;
			data_acked <= data_acked_n;
		end
	end

	////////////////////////////////////////
	// line command
	////////////////////////////////////////

	always_comb
	begin
		case (byte_sel_n)
			sccb_pkg::device_address:
				shift_byte = frame.dev_addr;
			sccb_pkg::register_address:
				shift_byte = frame.reg_addr;
			default:
				shift_byte = frame.data_byte;
		endcase
	end

	// decoded from the next state, the driver registers it into place
	always_comb
	begin
		cmd.sda_oe = 1'b1;
		cmd.scl_mode = sccb_pkg::scl_hold_high;
		cmd.frame_done = (state == sccb_pkg::stop_sda_high);
		cmd.data_ack_ok = data_acked;
		case (state_n)
			sccb_pkg::start_low_sda:
			begin
				cmd.sda = 1'b0;
			end
			sccb_pkg::start_low_scl:
			begin
				cmd.sda = 1'b0;
				cmd.scl_mode = sccb_pkg::scl_hold_low;
			end
			sccb_pkg::byte_shift:
			begin
				cmd.sda = shift_byte[bit_cnt_n];
				// scl already low after the start
				cmd.scl_mode = (state == sccb_pkg::start_low_scl) ?
					sccb_pkg::scl_hold_low : sccb_pkg::scl_toggle;
			end
			sccb_pkg::ack_slot:
			begin
				cmd.sda = 1'b1;
				cmd.sda_oe = 1'b0;
				cmd.scl_mode = sccb_pkg::scl_toggle;
			end
			sccb_pkg::stop_scl_high:
			begin
				cmd.sda = 1'b0;
			end
			default:
			begin
				cmd.sda = 1'b1;
			end
		endcase
	end

endmodule

/* sccb_reg_bank.sv */
`timescale 1ns/1ps

module sccb_reg_bank
(
	input logic clk_div_2,
	input logic reset_n,
	input sccb_pkg::host_write_t host,
	input logic busy,
	output sccb_pkg::sccb_frame_t frame,
	output logic go
);

	logic ctrl_write;

	assign ctrl_write = host.write && (host.address == sccb_pkg::reg_control);

	// frame fields, picked up bit by bit by the sequencer
	always_ff @(posedge clk_div_2)
	begin
		if (host.write)
		begin
			case (host.address)
				sccb_pkg::reg_slave_address:
					frame.dev_addr <= host.writedata;
				sccb_pkg::reg_reg_address:
					frame.reg_addr <= host.writedata;
				sccb_pkg::reg_data:
					frame.data_byte <= host.writedata;
				default:
					frame <= frame;
			endcase
		end
	end

	// only the go bit of the control register is kept
	always_ff @(posedge clk_div_2)
	begin
		if (!reset_n)
		begin
			go <= 1'b0;
		end
		else if (busy)
		begin
			// one write, one frame; writes during a frame are dropped
			go <= 1'b0;
		end
		else if (ctrl_write)
		begin
			go <= host.writedata[sccb_pkg::go_bit];
		end
	end

endmodule

/* sccb_pkg.sv */
package sccb_pkg;

	////////////////////////////////////////
	// timing and sizes
	////////////////////////////////////////

	localparam int byte_bits = 8;

	// counts down from the msb of a byte
	typedef logic [$clog2(byte_bits)-1:0] bit_index_t;

	////////////////////////////////////////
	// host register map
	////////////////////////////////////////

	typedef logic [2:0] reg_addr_t;

	localparam reg_addr_t reg_control = 3'd0;
	localparam reg_addr_t reg_slave_address = 3'd1;
	localparam reg_addr_t reg_reg_address = 3'd2;
	localparam reg_addr_t reg_data = 3'd3;

	localparam int go_bit = 0;

	////////////////////////////////////////
	// frame sequencing
	////////////////////////////////////////

	typedef enum logic [2:0]
	{
		idle,
		start_low_sda,
		start_low_scl,
		byte_shift,
		ack_slot,
		stop_scl_high,
		stop_sda_high
	} frame_state_t;

	typedef enum logic [1:0]
	{
		device_address,
		register_address,
		data
	} byte_sel_t;

	typedef enum logic [1:0]
	{
		scl_toggle,
		scl_hold_high,
		scl_hold_low
	} scl_mode_t;

	typedef struct packed
	{
		logic write;
		reg_addr_t address;
		logic [7:0] writedata;
	} host_write_t;

	typedef struct packed
	{
		logic [byte_bits-1:0] dev_addr;
		logic [byte_bits-1:0] reg_addr;
		logic [byte_bits-1:0] data_byte;
	} sccb_frame_t;

	typedef struct packed
	{
		logic sda;
		logic sda_oe;
		scl_mode_t scl_mode;
		logic frame_done;
		logic data_ack_ok;
	} line_cmd_t;

	typedef struct packed
	{
		logic scl;
		logic sda;
		logic sda_oe;
	} sccb_bus_t;

endpackage
